/* rtl/accel_pkg.sv */
package accel_pkg;

  // **************************************************
  // sizes
  // **************************************************

  // scratch memory word address, 256 words
  localparam int mem_addr_w = 8;
  localparam int mem_words = 1 << mem_addr_w;
  localparam int data_w = 32;
  // request queue depth, kept a power of two
  localparam int req_depth = 4;
  localparam int ptr_w = $clog2(req_depth);
  localparam int cnt_w = $clog2(req_depth + 1);
  // operand pair count width
  localparam int len_w = 8;

  // **************************************************
  // host register map
  // **************************************************

  // wishbone word address, top bit opens the memory window
  localparam int adr_w = 9;
  localparam int win_bit = 8;

  localparam logic [mem_addr_w-1:0] reg_ctrl = 8'd0;
  localparam logic [mem_addr_w-1:0] reg_len = 8'd1;
  localparam logic [mem_addr_w-1:0] reg_a_base = 8'd2;
  localparam logic [mem_addr_w-1:0] reg_b_base = 8'd3;
  localparam logic [mem_addr_w-1:0] reg_dst = 8'd4;
  localparam logic [mem_addr_w-1:0] reg_start_lo = 8'd5;
  localparam logic [mem_addr_w-1:0] reg_start_hi = 8'd6;
  localparam logic [mem_addr_w-1:0] reg_end_lo = 8'd7;
  localparam logic [mem_addr_w-1:0] reg_end_hi = 8'd8;

  // ctrl bits, start on write, busy and done on read
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_busy_bit = 0;
  localparam int ctrl_done_bit = 1;

  // **************************************************
  // bus types
  // **************************************************

  typedef struct packed {
    logic                  we;
    logic [mem_addr_w-1:0] addr;
    logic [data_w-1:0]     wdata;
  } mem_req_t;

  typedef struct packed {
    logic              is_write;
    logic [data_w-1:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic                  en;
    logic                  we;
    logic [mem_addr_w-1:0] addr;
    logic [data_w-1:0]     wdata;
  } host_mem_t;

  typedef struct packed {
    logic [len_w-1:0]      len;
    logic [mem_addr_w-1:0] a_base;
    logic [mem_addr_w-1:0] b_base;
    logic [mem_addr_w-1:0] dst;
  } run_cfg_t;

  // driver run states
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_await_done
  } drv_state_e;

endpackage

/* rtl/run_driver.sv */
`timescale 1ns/1ps

module run_driver
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [adr_w-1:0]  adr,
  input  logic [data_w-1:0] dat_w,
  input  logic              done,
  input  logic [data_w-1:0] mem_rdata,
  output logic [data_w-1:0] dat_r,
  output logic              ack,
  output logic              start,
  output run_cfg_t          cfg,
  output host_mem_t         host_mem
);

  drv_state_e            state;
  logic [63:0]           cycle_cnt;
  logic [63:0]           start_ts;
  logic [63:0]           end_ts;
  logic                  done_flag;
  logic                  busy;
  logic                  access;
  logic                  reg_acc;
  logic                  reg_wr;
  logic                  start_req;
  logic [mem_addr_w-1:0] reg_adr;
  logic [data_w-1:0]     reg_rdata;
  logic [data_w-1:0]     reg_rdata_q;
  logic                  mem_sel_q;

  // **************************************************
  // wishbone decode
  // **************************************************

  // new access only when no ack is pending
  assign access = cyc & stb & ~ack;
  assign reg_acc = access & ~adr[win_bit];
  assign reg_wr = reg_acc & we;
  assign reg_adr = adr[mem_addr_w-1:0];
  assign busy = (state != st_idle);
  assign start_req = reg_wr && (reg_adr == reg_ctrl) && dat_w[ctrl_start_bit];

  // memory window straight to the host port
  always_comb begin
    host_mem.en = access & adr[win_bit];
    host_mem.we = we;
    host_mem.addr = adr[mem_addr_w-1:0];
    host_mem.wdata = dat_w;
  end

  // single cycle ack, remember which side answers
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      mem_sel_q <= 1'b0;
    end else begin
      ack <= access;
      mem_sel_q <= access & adr[win_bit];
    end
  end

  // register read mux
  always_comb begin
    reg_rdata = '0;
    case (reg_adr)
      reg_ctrl: begin
        reg_rdata[ctrl_busy_bit] = busy;
        reg_rdata[ctrl_done_bit] = done_flag;
      end
      reg_len: reg_rdata = data_w'(cfg.len);
      reg_a_base: reg_rdata = data_w'(cfg.a_base);
      reg_b_base: reg_rdata = data_w'(cfg.b_base);
      reg_dst: reg_rdata = data_w'(cfg.dst);
      reg_start_lo: reg_rdata = start_ts[31:0];
      reg_start_hi: reg_rdata = start_ts[63:32];
      reg_end_lo: reg_rdata = end_ts[31:0];
      reg_end_hi: reg_rdata = end_ts[63:32];
      default: reg_rdata = '0;
    endcase
  end

  // read word held through the ack cycle
  always_ff @(posedge clk) begin
    if (reg_acc) begin
      reg_rdata_q <= reg_rdata;
    end
  end

  // memory word arrives one cycle after the host port request
  assign dat_r = mem_sel_q ? mem_rdata : reg_rdata_q;

  // **************************************************
  // run parameters
  // **************************************************

  // frozen while a run is in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
    end else if (reg_wr && !busy) begin
      case (reg_adr)
        reg_len: cfg.len <= dat_w[len_w-1:0];
        reg_a_base: cfg.a_base <= dat_w[mem_addr_w-1:0];
        reg_b_base: cfg.b_base <= dat_w[mem_addr_w-1:0];
        reg_dst: cfg.dst <= dat_w[mem_addr_w-1:0];
        default: ;
      endcase
    end
  end

  // **************************************************
  // cycle counter and run fsm
  // **************************************************

  // free running timestamp base
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      start <= 1'b0;
      done_flag <= 1'b0;
      start_ts <= '0;
      end_ts <= '0;
    end else begin
      // start is a single pulse
      start <= 1'b0;
      case (state)
        st_idle: begin
          // start write while busy never reaches here
          if (start_req) begin
            state <= st_start;
            done_flag <= 1'b0;
          end
        end
        st_start: begin
          start <= 1'b1;
          start_ts <= cycle_cnt;
          state <= st_await_done;
        end
        st_await_done: begin
          if (done) begin
            end_ts <= cycle_cnt;
            done_flag <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* rtl/dot_engine.sv */
`timescale 1ns/1ps

module dot_engine
  import accel_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  run_cfg_t  cfg,
  input  logic      full,
  input  logic      resp_valid,
  input  mem_resp_t resp,
  output logic      req_valid,
  output mem_req_t  req,
  output logic      done
);

  run_cfg_t              cfg_q;
  logic                  busy;
  logic                  wr_sent;
  logic [len_w:0]        total;
  logic [len_w:0]        issue_cnt;
  logic [len_w:0]        resp_cnt;
  logic [data_w-1:0]     a_hold;
  logic [data_w-1:0]     acc;
  logic                  reads_left;
  logic                  sum_ready;
  logic                  push;
  logic                  rd_resp;
  logic [mem_addr_w-1:0] pair_idx;

  // **************************************************
  // request issue
  // **************************************************

  // two reads per operand pair
  assign total = {cfg_q.len, 1'b0};
  assign reads_left = (issue_cnt != total);
  // sum is final once every read response is in
  assign sum_ready = !reads_left && (resp_cnt == total) && !wr_sent;
  // pair index, even reads go to a, odd to b
  assign pair_idx = mem_addr_w'(issue_cnt[len_w:1]);
  assign push = req_valid & ~full;
  assign rd_resp = resp_valid & ~resp.is_write;

  // request built from counters only, so it holds while full
  always_comb begin
    req_valid = busy && (reads_left || sum_ready);
    req.we = !reads_left;
    if (reads_left) begin
      req.addr = issue_cnt[0] ? cfg_q.b_base + pair_idx : cfg_q.a_base + pair_idx;
      req.wdata = '0;
    end else begin
      req.addr = cfg_q.dst;
      req.wdata = acc;
    end
  end

  // **************************************************
  // run control
  // **************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      wr_sent <= 1'b0;
      issue_cnt <= '0;
      resp_cnt <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        wr_sent <= 1'b0;
        issue_cnt <= '0;
        resp_cnt <= '0;
      end else if (busy) begin
        // count accepted reads
        if (push && reads_left) begin
          issue_cnt <= issue_cnt + 1'b1;
        end
        // result write left in the queue
        if (push && !reads_left) begin
          wr_sent <= 1'b1;
        end
        if (rd_resp) begin
          resp_cnt <= resp_cnt + 1'b1;
        end
        // write ack closes the run
        if (resp_valid && resp.is_write) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // **************************************************
  // multiply accumulate
  // **************************************************

  // cfg snapshot for the run
  always_ff @(posedge clk) begin
    if (start) begin
      cfg_q <= cfg;
    end
  end

  // responses come back in order, a then b
  always_ff @(posedge clk) begin
    if (start) begin
      acc <= '0;
    end else if (rd_resp) begin
      if (!resp_cnt[0]) begin
        a_hold <= resp.rdata;
      end else begin
        // low word of the product, wrapping sum
        acc <= acc + a_hold * resp.rdata;
      end
    end
  end

endmodule

/* rtl/mem_req_fifo.sv */
`timescale 1ns/1ps

module mem_req_fifo
  import accel_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  mem_req_t din,
  input  logic     pop,
  output mem_req_t head,
  output logic     full,
  output logic     empty
);

  mem_req_t         slots [req_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // flow control from occupancy
  assign full = (count == cnt_w'(req_depth));
  assign empty = (count == '0);
  assign do_push = push & ~full;
  assign do_pop = pop & ~empty;
  // oldest entry always on the head
  assign head = slots[rd_ptr];

  // payload storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= din;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/scratch_mem.sv */
`timescale 1ns/1ps

module scratch_mem
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              empty,
  input  mem_req_t          head,
  input  host_mem_t         host_mem,
  output logic              pop,
  output logic              resp_valid,
  output mem_resp_t         resp,
  output logic [data_w-1:0] host_rdata
);

  logic [data_w-1:0] mem [mem_words];

  // **************************************************
  // queued request port
  // **************************************************

  // drain one request every cycle
  assign pop = ~empty;

  // response one cycle after the pop
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= pop;
    end
  end

  // **************************************************
  // storage
  // **************************************************

  // host only touches memory while the driver is idle
  always_ff @(posedge clk) begin
    if (pop) begin
      if (head.we) begin
        mem[head.addr] <= head.wdata;
      end
      // read data, or old word on a write ack
      resp.rdata <= mem[head.addr];
      resp.is_write <= head.we;
    end
    // host port, registered read
    if (host_mem.en) begin
      if (host_mem.we) begin
        mem[host_mem.addr] <= host_mem.wdata;
      end
      host_rdata <= mem[host_mem.addr];
    end
  end

endmodule

/* rtl/accel_top.sv */
`timescale 1ns/1ps

module accel_top
  import accel_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [adr_w-1:0]  adr,
  input  logic [data_w-1:0] dat_w,
  output logic [data_w-1:0] dat_r,
  output logic              ack
);

  // driver and engine
  logic              start;
  logic              done;
  run_cfg_t          cfg;
  // host memory window
  host_mem_t         host_mem;
  logic [data_w-1:0] host_rdata;
  // request path
  logic              req_valid;
  mem_req_t          req;
  logic              full;
  logic              empty;
  mem_req_t          head;
  logic              pop;
  // response path
  logic              resp_valid;
  mem_resp_t         resp;

  // **************************************************
  // host side, run control
  // **************************************************

  run_driver i_run_driver (
    .clk       (clk),
    .rst       (rst),
    .cyc       (cyc),
    .stb       (stb),
    .we        (we),
    .adr       (adr),
    .dat_w     (dat_w),
    .done      (done),
    .mem_rdata (host_rdata),
    .dat_r     (dat_r),
    .ack       (ack),
    .start     (start),
    .cfg       (cfg),
    .host_mem  (host_mem)
  );

  // **************************************************
  // producer, queue, consumer
  // **************************************************

  dot_engine i_dot_engine (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .cfg        (cfg),
    .full       (full),
    .resp_valid (resp_valid),
    .resp       (resp),
    .req_valid  (req_valid),
    .req        (req),
    .done       (done)
  );

  mem_req_fifo i_mem_req_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (req_valid),
    .din   (req),
    .pop   (pop),
    .head  (head),
    .full  (full),
    .empty (empty)
  );

  scratch_mem i_scratch_mem (
    .clk        (clk),
    .rst        (rst),
    .empty      (empty),
    .head       (head),
    .host_mem   (host_mem),
    .pop        (pop),
    .resp_valid (resp_valid),
    .resp       (resp),
    .host_rdata (host_rdata)
  );

endmodule

/* testbench/tb_tests.svh */
// **************************************************
// run helpers
// **************************************************

task automatic fill_random(input int len);
  for (int i = 0; i < len; i++) begin
    a_vals[i] = next_rand();
    b_vals[i] = next_rand();
  end
endtask

// low 32 bits of each product, sum wraps at 32 bits
function automatic logic [data_w-1:0] model_dot(input int len);
  logic [data_w-1:0] sum;
  sum = '0;
  for (int i = 0; i < len; i++) begin
    sum = sum + a_vals[i] * b_vals[i];
  end
  return sum;
endfunction

task automatic write_operands(input int len, input logic [mem_addr_w-1:0] a_base, b_base);
  for (int i = 0; i < len; i++) begin
    wb_write(mem_at(a_base + mem_addr_w'(i)), a_vals[i]);
    wb_write(mem_at(b_base + mem_addr_w'(i)), b_vals[i]);
  end
endtask

// poll ctrl until the sticky done bit shows up
task automatic wait_done(output logic [data_w-1:0] ctrl);
  int polls;
  polls = 0;
  do begin
    wb_read(reg_at(reg_ctrl), ctrl);
    polls++;
    if (polls > poll_limit) begin
      $display("run never reported done after %0d status polls", poll_limit);
      end_with_failure();
    end
  end while (ctrl[ctrl_done_bit] !== 1'b1);
endtask

task automatic read_times(output logic [63:0] t_start, t_end);
  logic [data_w-1:0] lo;
  logic [data_w-1:0] hi;
  wb_read(reg_at(reg_start_lo), lo);
  wb_read(reg_at(reg_start_hi), hi);
  t_start = {hi, lo};
  wb_read(reg_at(reg_end_lo), lo);
  wb_read(reg_at(reg_end_hi), hi);
  t_end = {hi, lo};
endtask

// one complete run, poke_busy adds a second start mid run
task automatic do_run(input string name, input int len,
                      input logic [mem_addr_w-1:0] a_base, b_base, dst,
                      input bit poke_busy, output logic [data_w-1:0] result,
                      output logic [63:0] t_start, t_end);
  logic [data_w-1:0] ctrl;
  wb_write(reg_at(reg_len), data_w'(len));
  wb_write(reg_at(reg_a_base), data_w'(a_base));
  wb_write(reg_at(reg_b_base), data_w'(b_base));
  wb_write(reg_at(reg_dst), data_w'(dst));
  write_operands(len, a_base, b_base);
  // stale word at dst, so the result write is visible
  wb_write(mem_at(dst), ~model_dot(len));
  wb_write(reg_at(reg_ctrl), 32'h1);
  if (poke_busy) begin
    wb_read(reg_at(reg_ctrl), ctrl);
    check({name, " busy"}, 64'(1), 64'(ctrl[ctrl_busy_bit]));
    wb_write(reg_at(reg_ctrl), 32'h1);
  end
  wait_done(ctrl);
  // idle with done set
  check({name, " ctrl"}, 64'h2, 64'(ctrl));
  wb_read(mem_at(dst), result);
  check({name, " result"}, 64'(model_dot(len)), 64'(result));
  read_times(t_start, t_end);
endtask

// **************************************************
// directed tests
// **************************************************

task automatic test_reg_access();
  logic [mem_addr_w-1:0] regs [4];
  logic [data_w-1:0]     want [4];
  logic [data_w-1:0]     got;
  regs = '{reg_len, reg_a_base, reg_b_base, reg_dst};
  wb_read(reg_at(reg_ctrl), got);
  check("reg_access ctrl", 64'(0), 64'(got));
  for (int i = 0; i < 4; i++) begin
    want[i] = next_rand() & 32'hff;
    wb_write(reg_at(regs[i]), want[i]);
  end
  for (int i = 0; i < 4; i++) begin
    wb_read(reg_at(regs[i]), got);
    check("reg_access", 64'(want[i]), 64'(got));
  end
endtask

task automatic test_mem_window();
  logic [data_w-1:0] want [32];
  logic [data_w-1:0] got;
  for (int i = 0; i < 32; i++) begin
    want[i] = next_rand();
    wb_write(mem_at(mem_addr_w'(i * 8 + 5)), want[i]);
  end
  for (int i = 0; i < 32; i++) begin
    wb_read(mem_at(mem_addr_w'(i * 8 + 5)), got);
    check("mem_window", 64'(want[i]), 64'(got));
  end
endtask

task automatic test_directed_dot();
  logic [data_w-1:0] res;
  logic [63:0]       ts;
  logic [63:0]       te;
  a_vals[0:3] = '{32'd3, 32'h1_0000, 32'hffff_ffff, 32'd7};
  b_vals[0:3] = '{32'd5, 32'h1_0000, 32'd2, 32'd11};
  do_run("directed_dot", 4, 8'h10, 8'h20, 8'h90, 1'b0, res, ts, te);
  // 15 + 0 + fffffffe + 77, carry out of bit 31 dropped
  check("directed_dot value", 64'h5a, 64'(res));
endtask

task automatic test_random_runs();
  int                    len;
  logic [mem_addr_w-1:0] a_base;
  logic [mem_addr_w-1:0] b_base;
  logic [mem_addr_w-1:0] dst;
  logic [data_w-1:0]     res;
  logic [63:0]           ts;
  logic [63:0]           te;
  for (int r = 0; r < 6; r++) begin
    len = int'(next_rand() % 16) + 1;
    // a base below 48, b base in 64..111, dst in the upper half
    a_base = mem_addr_w'(next_rand() % 48);
    b_base = mem_addr_w'(64 + next_rand() % 48);
    dst = mem_addr_w'(128 + next_rand() % 128);
    fill_random(len);
    do_run("random_run", len, a_base, b_base, dst, 1'b0, res, ts, te);
  end
  // empty run still writes a zero sum
  do_run("len_zero", 0, 8'h00, 8'h40, 8'hc0, 1'b0, res, ts, te);
  check("len_zero value", 64'(0), 64'(res));
endtask

task automatic test_timestamps();
  logic [data_w-1:0] res;
  logic [63:0]       s1;
  logic [63:0]       e1;
  logic [63:0]       s2;
  logic [63:0]       e2;
  fill_random(8);
  do_run("timestamps", 8, 8'h08, 8'h48, 8'ha0, 1'b0, res, s1, e1);
  check("timestamps end after start", 64'(1), 64'(e1 > s1));
  check("timestamps min length", 64'(1), 64'((e1 - s1) >= 64'(16)));
  do_run("timestamps", 8, 8'h08, 8'h48, 8'ha0, 1'b0, res, s2, e2);
  check("timestamps second start", 64'(1), 64'(s2 > e1));
endtask

task automatic test_busy_start();
  logic [data_w-1:0] res1;
  logic [data_w-1:0] res2;
  logic [data_w-1:0] ctrl;
  logic [63:0]       s1;
  logic [63:0]       e1;
  logic [63:0]       s2;
  logic [63:0]       e2;
  fill_random(16);
  do_run("busy_ref", 16, 8'h00, 8'h40, 8'hf0, 1'b0, res1, s1, e1);
  do_run("busy_start", 16, 8'h00, 8'h40, 8'hf0, 1'b1, res2, s2, e2);
  check("busy_start result", 64'(res1), 64'(res2));
  // engine timing is fixed, so equal length means one run only
  check("busy_start length", e1 - s1, e2 - s2);
  check("busy_start order", 64'(1), 64'(s2 > e1));
  repeat (20) @(negedge clk);
  wb_read(reg_at(reg_ctrl), ctrl);
  check("busy_start no restart", 64'h2, 64'(ctrl));
endtask

/* testbench/tb_accel_top.sv */
`timescale 1ns/1ps

module tb_accel_top
  import accel_pkg::*;
();

  // watchdog budget and bus limits
  localparam int n_runs = 12;
  localparam int run_cycles = 200;
  localparam int overhead_cycles = 2000;
  localparam int bus_limit = 20;
  localparam int poll_limit = 200;
  localparam int max_len = 16;

  logic              clk;
  logic              rst;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [adr_w-1:0]  adr;
  logic [data_w-1:0] dat_w;
  logic [data_w-1:0] dat_r;
  logic              ack;

  logic [31:0]       rng_state = 32'hda31;
  // operand words of the current run, the model works on these
  logic [data_w-1:0] a_vals [max_len];
  logic [data_w-1:0] b_vals [max_len];

  accel_top i_accel_top (
    .clk   (clk),
    .rst   (rst),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // **************************************************
  // failure reporting and checks
  // **************************************************

  task automatic end_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
      end_with_failure();
    end
  endtask

  // xorshift32, stimulus data
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // **************************************************
  // wishbone master
  // **************************************************

  // register space, window bit low
  function automatic logic [adr_w-1:0] reg_at(input logic [mem_addr_w-1:0] r);
    return {1'b0, r};
  endfunction

  // memory window, window bit high
  function automatic logic [adr_w-1:0] mem_at(input logic [mem_addr_w-1:0] a);
    return {1'b1, a};
  endfunction

  // ack sampled on the falling edge, stable there
  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > bus_limit) begin
        $display("no wishbone ack within %0d cycles, address %0h", bus_limit, adr);
        end_with_failure();
      end
    end while (ack !== 1'b1);
  endtask

  task automatic wb_write(input logic [adr_w-1:0] a, input logic [data_w-1:0] d);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b1;
    adr = a;
    dat_w = d;
    wait_ack();
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
  endtask

  task automatic wb_read(input logic [adr_w-1:0] a, output logic [data_w-1:0] d);
    @(negedge clk);
    cyc = 1'b1;
    stb = 1'b1;
    we = 1'b0;
    adr = a;
    wait_ack();
    // dat_r valid while ack is high
    d = dat_r;
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  `include "tb_tests.svh"

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reg_access();
    test_mem_window();
    test_directed_dot();
    test_random_runs();
    test_timestamps();
    test_busy_start();
    $display("STATUS: PASS");
    $finish;
  end

  // hang guard, scaled by the number of runs
  initial begin
    repeat (n_runs * run_cycles + overhead_cycles) @(posedge clk);
    $display("watchdog expired, the simulation hung before the tests finished");
    end_with_failure();
  end

endmodule

/* all.f */
+incdir+testbench
rtl/accel_pkg.sv
rtl/run_driver.sv
rtl/dot_engine.sv
rtl/mem_req_fifo.sv
rtl/scratch_mem.sv
rtl/accel_top.sv
testbench/tb_accel_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f all.f \
    --top-module tb_accel_top -Mdir obj_dir -o tb_sim; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "STATUS: PASS"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
